/* src/dbg_defines.svh */
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// Datapath and frame widths

`define DBG_WORD_W 32        // Datapath word

`define DBG_BYTE_W 8         // One frame byte

`define DBG_PC_W 8           // PC and jump address

`define DBG_REG_W 5          // Register index

// Frame geometry

`define DBG_FRAME_BYTES 56   // IF 6 + ID 23 + EX 16 + MEM 11

`define DBG_IDX_W 6          // Enough for 0..55

`endif

/* src/dbg_pkg.sv */
`default_nettype none

`include "dbg_defines.svh"

package dbg_pkg;

  // Two-bit ALUOp as issued by decode
  typedef enum logic [1:0] {
    alu_op_add   = 2'b00,   // Loads and stores
    alu_op_sub   = 2'b01,   // Branch compare
    alu_op_rtype = 2'b10,   // Use funct field
    alu_op_rsvd  = 2'b11    // Not generated by decode
  } alu_op_e;

  // Fetch part, 6 bytes
  typedef struct packed {
    logic [`DBG_PC_W-1:0]   current_pc;    // PC of next instruction
    logic [`DBG_PC_W-1:0]   pc_if_out;     // PC used for target calc
    logic [`DBG_WORD_W-1:0] instruction;   // Fetched word
  } if_snap_t;

  // Decode part, 23 bytes
  typedef struct packed {
    logic [`DBG_WORD_W-1:0] data_a;           // Operand A
    logic [`DBG_WORD_W-1:0] data_b;           // Operand B
    logic [`DBG_WORD_W-1:0] sign_extend;      // Immediate after sign extension
    logic [`DBG_PC_W-1:0]   jump_dest;        // Jump target
    logic [`DBG_REG_W-1:0]  reg_dest_r_type;  // rd field
    logic [`DBG_REG_W-1:0]  reg_dest_l_type;  // rt field
    logic                   reg_dst;
    logic                   alu_src;
    logic                   mem_to_reg;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   branch;
    alu_op_e                alu_op;           // Sent as its own byte
  } id_snap_t;

  // Execute part, 16 bytes
  typedef struct packed {
    logic [`DBG_WORD_W-1:0] alu_result;       // ALU output at EX/MEM
    logic [`DBG_WORD_W-1:0] reg_2_value;      // Forwarded rt value
    logic [`DBG_PC_W-1:0]   jump_dest_addr;   // Branch target at EX/MEM
    logic                   zero;             // ALU zero flag
    logic [`DBG_REG_W-1:0]  reg_dest;         // Selected destination
    logic                   mem_to_reg;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   branch;
  } ex_snap_t;

  // Memory part, 11 bytes
  typedef struct packed {
    logic [`DBG_WORD_W-1:0] mem_data;         // Load data at MEM/WB
    logic [`DBG_WORD_W-1:0] alu_result;       // ALU result at MEM/WB
    logic [`DBG_REG_W-1:0]  reg_dest;         // Writeback target
    logic                   mem_to_reg;
    logic                   reg_write;
  } mem_snap_t;

  // Readout controller states
  typedef enum logic {
    st_idle   = 1'b0,   // No frame held, empty high
    st_loaded = 1'b1    // Frame held, bytes pending
  } readout_state_e;

endpackage

`default_nettype wire

/* src/snapshot_if.sv */
`default_nettype none
`timescale 1ns/10ps

// Latched snapshot from capture registers to the byte mux
interface snapshot_if;

  dbg_pkg::if_snap_t  if_snap;    // Fetch fields
  dbg_pkg::id_snap_t  id_snap;    // Decode fields and control
  dbg_pkg::ex_snap_t  ex_snap;    // Execute fields and control
  dbg_pkg::mem_snap_t mem_snap;   // Memory fields and control

  // Register side
  modport capture (
    output if_snap,
    output id_snap,
    output ex_snap,
    output mem_snap
  );

  // Frame mux side
  modport select (
    input if_snap,
    input id_snap,
    input ex_snap,
    input mem_snap
  );

endinterface

`default_nettype wire

/* src/stage_capture.sv */
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defines.svh"

module stage_capture (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   capture_en,               // Accepted write strobe
  // Fetch
  input  logic [`DBG_PC_W-1:0]   current_pc,
  input  logic [`DBG_PC_W-1:0]   pc_if_out,
  input  logic [`DBG_WORD_W-1:0] instruction_if_out,
  // Decode
  input  logic [`DBG_WORD_W-1:0] data_a_id_out,
  input  logic [`DBG_WORD_W-1:0] data_b_id_out,
  input  logic [`DBG_WORD_W-1:0] sign_extend_id_out,
  input  logic [`DBG_PC_W-1:0]   jump_dest_id_out,
  input  logic [`DBG_REG_W-1:0]  reg_dest_r_type_id_out,
  input  logic [`DBG_REG_W-1:0]  reg_dest_l_type_id_out,
  input  logic                   reg_dst_id_out,
  input  logic                   alu_src_id_out,
  input  logic                   mem_to_reg_id_out,
  input  logic                   reg_write_id_out,
  input  logic                   mem_read_id_out,
  input  logic                   mem_write_id_out,
  input  logic                   branch_id_out,
  input  logic [1:0]             alu_op_id_out,            // Raw ALUOp code
  // Execute
  input  logic [`DBG_WORD_W-1:0] result_ie_out,
  input  logic [`DBG_WORD_W-1:0] registro_2_ie_out,
  input  logic [`DBG_PC_W-1:0]   jump_dest_addr_ie_out,
  input  logic                   zero_signal_ie_out,
  input  logic [`DBG_REG_W-1:0]  reg_dest_ie_out,
  input  logic                   mem_to_reg_ie_out,
  input  logic                   reg_write_ie_out,
  input  logic                   mem_read_ie_out,
  input  logic                   mem_write_ie_out,
  input  logic                   branch_ie_out,
  // Memory
  input  logic [`DBG_WORD_W-1:0] mem_data_mem_out,
  input  logic [`DBG_WORD_W-1:0] alu_result_mem_out,
  input  logic [`DBG_REG_W-1:0]  reg_dest_mem_out,
  input  logic                   mem_to_reg_mem_out,
  input  logic                   reg_write_mem_out,
  snapshot_if.capture            snap                      // Held snapshot out
);

  // All four parts load on the same edge so the frame is coherent
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      snap.if_snap  <= '0;
      snap.id_snap  <= '0;
      snap.ex_snap  <= '0;
      snap.mem_snap <= '0;
    end
    else if (capture_en)
    begin
      snap.if_snap.current_pc          <= current_pc;
      snap.if_snap.pc_if_out           <= pc_if_out;
      snap.if_snap.instruction         <= instruction_if_out;
      snap.id_snap.data_a              <= data_a_id_out;
      snap.id_snap.data_b              <= data_b_id_out;
      snap.id_snap.sign_extend         <= sign_extend_id_out;
      snap.id_snap.jump_dest           <= jump_dest_id_out;
      snap.id_snap.reg_dest_r_type     <= reg_dest_r_type_id_out;
      snap.id_snap.reg_dest_l_type     <= reg_dest_l_type_id_out;
      snap.id_snap.reg_dst             <= reg_dst_id_out;
      snap.id_snap.alu_src             <= alu_src_id_out;
      snap.id_snap.mem_to_reg          <= mem_to_reg_id_out;
      snap.id_snap.reg_write           <= reg_write_id_out;
      snap.id_snap.mem_read            <= mem_read_id_out;
      snap.id_snap.mem_write           <= mem_write_id_out;
      snap.id_snap.branch              <= branch_id_out;
      snap.id_snap.alu_op              <= dbg_pkg::alu_op_e'(alu_op_id_out);  // Raw to enum
      snap.ex_snap.alu_result          <= result_ie_out;
      snap.ex_snap.reg_2_value         <= registro_2_ie_out;
      snap.ex_snap.jump_dest_addr      <= jump_dest_addr_ie_out;
      snap.ex_snap.zero                <= zero_signal_ie_out;
      snap.ex_snap.reg_dest            <= reg_dest_ie_out;
      snap.ex_snap.mem_to_reg          <= mem_to_reg_ie_out;
      snap.ex_snap.reg_write           <= reg_write_ie_out;
      snap.ex_snap.mem_read            <= mem_read_ie_out;
      snap.ex_snap.mem_write           <= mem_write_ie_out;
      snap.ex_snap.branch              <= branch_ie_out;
      snap.mem_snap.mem_data           <= mem_data_mem_out;
      snap.mem_snap.alu_result         <= alu_result_mem_out;
      snap.mem_snap.reg_dest           <= reg_dest_mem_out;
      snap.mem_snap.mem_to_reg         <= mem_to_reg_mem_out;
      snap.mem_snap.reg_write          <= reg_write_mem_out;
    end
  end

  // Controller leaves idle on a capture, so no back-to-back loads
  a_no_double_capture : assert property (
    @(posedge clk) disable iff (reset)
    capture_en |=> !capture_en
  ) else $error("capture_en high in cycle after a capture");

endmodule

`default_nettype wire

/* src/frame_byte_select.sv */
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defines.svh"

module frame_byte_select (
  input  logic [`DBG_IDX_W-1:0]  byte_idx,    // Current read pointer
  snapshot_if.select             snap,        // Held snapshot in
  output logic [`DBG_BYTE_W-1:0] byte_data    // Frame byte at pointer
);

  // Byte 0 sits at index 0, the leftmost slot of each packed array
  logic [0:5][`DBG_BYTE_W-1:0]                   if_bytes;
  logic [0:22][`DBG_BYTE_W-1:0]                  id_bytes;
  logic [0:15][`DBG_BYTE_W-1:0]                  ex_bytes;
  logic [0:10][`DBG_BYTE_W-1:0]                  mem_bytes;
  logic [0:`DBG_FRAME_BYTES-1][`DBG_BYTE_W-1:0]  frame;

  // Single flag in bit 0
  function automatic logic [`DBG_BYTE_W-1:0] pad_bit(input logic b);
    return {{(`DBG_BYTE_W-1){1'b0}}, b};
  endfunction

  // Register index in the low bits
  function automatic logic [`DBG_BYTE_W-1:0] pad_reg(input logic [`DBG_REG_W-1:0] r);
    return {{(`DBG_BYTE_W-`DBG_REG_W){1'b0}}, r};
  endfunction

  // ALUOp code in bits 1:0
  function automatic logic [`DBG_BYTE_W-1:0] pad_op(input dbg_pkg::alu_op_e op);
    return {{(`DBG_BYTE_W-$bits(dbg_pkg::alu_op_e)){1'b0}}, op};
  endfunction

  // Words go MSB first
  assign if_bytes = {
    snap.if_snap.current_pc,     // Byte 0
    snap.if_snap.pc_if_out,      // Byte 1
    snap.if_snap.instruction     // Bytes 2..5
  };

  assign id_bytes = {
    snap.id_snap.data_a,                    // Bytes 6..9
    snap.id_snap.data_b,                    // Bytes 10..13
    snap.id_snap.sign_extend,               // Bytes 14..17
    snap.id_snap.jump_dest,                 // Byte 18
    pad_reg(snap.id_snap.reg_dest_r_type),
    pad_reg(snap.id_snap.reg_dest_l_type),
    pad_bit(snap.id_snap.reg_dst),          // Control bytes 21..27
    pad_bit(snap.id_snap.alu_src),
    pad_bit(snap.id_snap.mem_to_reg),
    pad_bit(snap.id_snap.reg_write),
    pad_bit(snap.id_snap.mem_read),
    pad_bit(snap.id_snap.mem_write),
    pad_bit(snap.id_snap.branch),
    pad_op(snap.id_snap.alu_op)             // Byte 28
  };

  assign ex_bytes = {
    snap.ex_snap.alu_result,                // Bytes 29..32
    snap.ex_snap.reg_2_value,               // Bytes 33..36
    snap.ex_snap.jump_dest_addr,            // Byte 37
    pad_bit(snap.ex_snap.zero),
    pad_reg(snap.ex_snap.reg_dest),
    pad_bit(snap.ex_snap.mem_to_reg),       // Control bytes 40..44
    pad_bit(snap.ex_snap.reg_write),
    pad_bit(snap.ex_snap.mem_read),
    pad_bit(snap.ex_snap.mem_write),
    pad_bit(snap.ex_snap.branch)
  };

  assign mem_bytes = {
    snap.mem_snap.mem_data,                 // Bytes 45..48
    snap.mem_snap.alu_result,               // Bytes 49..52
    pad_reg(snap.mem_snap.reg_dest),
    pad_bit(snap.mem_snap.mem_to_reg),
    pad_bit(snap.mem_snap.reg_write)        // Byte 55, last
  };

  assign frame     = {if_bytes, id_bytes, ex_bytes, mem_bytes};
  assign byte_data = frame[byte_idx];   // No register, straight to r_data

  // Pointer is X only before the first reset edge
  a_idx_in_range : assert final (
    $isunknown(byte_idx) || (byte_idx < `DBG_FRAME_BYTES)
  ) else $error("byte_idx %0d beyond frame", byte_idx);

endmodule

`default_nettype wire

/* src/readout_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defines.svh"

module readout_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wr,          // Capture strobe from host
  input  logic                  rd,          // Byte consume strobe
  output logic                  capture_en,  // Load snapshot this edge
  output logic [`DBG_IDX_W-1:0] byte_idx,    // Byte shown on r_data
  output logic                  empty        // No frame held
);

  dbg_pkg::readout_state_e state;
  logic                    rd_accept;   // Read of a held byte
  logic                    last_byte;   // Pointer on byte 55

  assign empty      = (state == dbg_pkg::st_idle);
  assign capture_en = wr && empty;                 // wr ignored while loaded
  assign rd_accept  = rd && !empty;                // rd ignored while idle
  assign last_byte  = (byte_idx == `DBG_IDX_W'(`DBG_FRAME_BYTES - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= dbg_pkg::st_idle;
      byte_idx <= '0;
    end
    else
    begin
      case (state)
        dbg_pkg::st_idle:
        begin
          if (capture_en)
          begin
            state    <= dbg_pkg::st_loaded;
            byte_idx <= '0;                        // Frame starts at byte 0
          end
        end
        dbg_pkg::st_loaded:
        begin
          if (rd_accept)
          begin
            if (last_byte)
            begin
              state    <= dbg_pkg::st_idle;        // Whole frame consumed
              byte_idx <= '0;
            end
            else
            begin
              byte_idx <= byte_idx + `DBG_IDX_W'(1);
            end
          end
        end
        default:
        begin
          state <= dbg_pkg::st_idle;
        end
      endcase
    end
  end

  // New frame always begins at byte 0
  a_ptr_zero_on_load : assert property (
    @(posedge clk) disable iff (reset)
    $rose(state == dbg_pkg::st_loaded) |-> (byte_idx == '0)
  ) else $error("pointer not zero on first loaded cycle");

  // Buffer empties right after the last byte is taken
  a_empty_after_last : assert property (
    @(posedge clk) disable iff (reset)
    (rd_accept && last_byte) |=> empty
  ) else $error("empty low after read of last byte");

endmodule

`default_nettype wire

/* src/pipeline_debug_buffer.sv */
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defines.svh"

module pipeline_debug_buffer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wr,                       // Capture strobe
  input  logic                   rd,                       // Byte read strobe
  // Fetch stage
  input  logic [`DBG_PC_W-1:0]   current_pc,
  input  logic [`DBG_PC_W-1:0]   pc_if_out,
  input  logic [`DBG_WORD_W-1:0] instruction_if_out,
  // Decode stage
  input  logic [`DBG_WORD_W-1:0] data_a_id_out,
  input  logic [`DBG_WORD_W-1:0] data_b_id_out,
  input  logic [`DBG_WORD_W-1:0] sign_extend_id_out,
  input  logic [`DBG_PC_W-1:0]   jump_dest_id_out,
  input  logic [`DBG_REG_W-1:0]  reg_dest_r_type_id_out,
  input  logic [`DBG_REG_W-1:0]  reg_dest_l_type_id_out,
  input  logic                   reg_dst_id_out,
  input  logic                   alu_src_id_out,
  input  logic                   mem_to_reg_id_out,
  input  logic                   reg_write_id_out,
  input  logic                   mem_read_id_out,
  input  logic                   mem_write_id_out,
  input  logic                   branch_id_out,
  input  logic [1:0]             alu_op_id_out,
  // Execute stage
  input  logic [`DBG_WORD_W-1:0] result_ie_out,
  input  logic [`DBG_WORD_W-1:0] registro_2_ie_out,
  input  logic [`DBG_PC_W-1:0]   jump_dest_addr_ie_out,
  input  logic                   zero_signal_ie_out,
  input  logic [`DBG_REG_W-1:0]  reg_dest_ie_out,
  input  logic                   mem_to_reg_ie_out,
  input  logic                   reg_write_ie_out,
  input  logic                   mem_read_ie_out,
  input  logic                   mem_write_ie_out,
  input  logic                   branch_ie_out,
  // Memory stage
  input  logic [`DBG_WORD_W-1:0] mem_data_mem_out,
  input  logic [`DBG_WORD_W-1:0] alu_result_mem_out,
  input  logic [`DBG_REG_W-1:0]  reg_dest_mem_out,
  input  logic                   mem_to_reg_mem_out,
  input  logic                   reg_write_mem_out,
  // Host side
  output logic                   empty,                    // High when no frame held
  output logic [`DBG_BYTE_W-1:0] r_data                    // Current frame byte
);

  logic                  capture_en;   // Controller to capture regs
  logic [`DBG_IDX_W-1:0] byte_idx;     // Controller to byte mux

  snapshot_if i_snap ();   // Captured stage state

  // Stage inputs connect by matching names
  stage_capture i_stage_capture (
    .*,
    .snap (i_snap.capture)
  );

  frame_byte_select i_frame_byte_select (
    .byte_idx  (byte_idx),
    .snap      (i_snap.select),
    .byte_data (r_data)
  );

  readout_ctrl i_readout_ctrl (
    .clk        (clk),
    .reset      (reset),
    .wr         (wr),
    .rd         (rd),
    .capture_en (capture_en),
    .byte_idx   (byte_idx),
    .empty      (empty)
  );

endmodule

`default_nettype wire

/* dv/tb_pipeline_debug_buffer.sv */
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defines.svh"

module tb_pipeline_debug_buffer;

  localparam int CLK_PERIOD      = 100;                             // ns
  localparam int REC_COUNT       = 4;                               // Snapshots in data file
  localparam int FIELD_COUNT     = 32;                              // Stage values per record
  localparam int REC_LEN         = FIELD_COUNT + `DBG_FRAME_BYTES;  // Values plus frame bytes
  localparam int MAX_GAP         = 3;                               // Idle cycles between reads
  localparam int PROBE_IDX       = 20;                              // Byte where stray wr lands
  localparam int WATCHDOG_CYCLES = REC_COUNT * `DBG_FRAME_BYTES * (MAX_GAP + 2) + 200;

  logic                   clk;
  logic                   reset;
  logic                   wr;
  logic                   rd;
  logic [`DBG_PC_W-1:0]   current_pc;
  logic [`DBG_PC_W-1:0]   pc_if_out;
  logic [`DBG_WORD_W-1:0] instruction_if_out;
  logic [`DBG_WORD_W-1:0] data_a_id_out;
  logic [`DBG_WORD_W-1:0] data_b_id_out;
  logic [`DBG_WORD_W-1:0] sign_extend_id_out;
  logic [`DBG_PC_W-1:0]   jump_dest_id_out;
  logic [`DBG_REG_W-1:0]  reg_dest_r_type_id_out;
  logic [`DBG_REG_W-1:0]  reg_dest_l_type_id_out;
  logic                   reg_dst_id_out;
  logic                   alu_src_id_out;
  logic                   mem_to_reg_id_out;
  logic                   reg_write_id_out;
  logic                   mem_read_id_out;
  logic                   mem_write_id_out;
  logic                   branch_id_out;
  logic [1:0]             alu_op_id_out;
  logic [`DBG_WORD_W-1:0] result_ie_out;
  logic [`DBG_WORD_W-1:0] registro_2_ie_out;
  logic [`DBG_PC_W-1:0]   jump_dest_addr_ie_out;
  logic                   zero_signal_ie_out;
  logic [`DBG_REG_W-1:0]  reg_dest_ie_out;
  logic                   mem_to_reg_ie_out;
  logic                   reg_write_ie_out;
  logic                   mem_read_ie_out;
  logic                   mem_write_ie_out;
  logic                   branch_ie_out;
  logic [`DBG_WORD_W-1:0] mem_data_mem_out;
  logic [`DBG_WORD_W-1:0] alu_result_mem_out;
  logic [`DBG_REG_W-1:0]  reg_dest_mem_out;
  logic                   mem_to_reg_mem_out;
  logic                   reg_write_mem_out;
  logic                   empty;
  logic [`DBG_BYTE_W-1:0] r_data;

  logic [31:0] rec_mem [0:REC_COUNT*REC_LEN-1];   // Whole data file
  integer      seed;                              // Read gap generator state

  pipeline_debug_buffer i_pipeline_debug_buffer (.*);   // Names match one to one

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Non-compare failures end here
  task automatic abort_run(input string reason);
    $display("Error at time %0t: %s", $time, reason);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // One record's stage values onto the ports, mask of all ones inverts them
  task automatic drive_fields(input int base, input logic [31:0] mask);
    logic [31:0] f [0:FIELD_COUNT-1];
    for (int i = 0; i < FIELD_COUNT; i++)
    begin
      f[i] = rec_mem[base + i] ^ mask;
    end
    current_pc             <= f[0][`DBG_PC_W-1:0];
    pc_if_out              <= f[1][`DBG_PC_W-1:0];
    instruction_if_out     <= f[2];
    data_a_id_out          <= f[3];
    data_b_id_out          <= f[4];
    sign_extend_id_out     <= f[5];
    jump_dest_id_out       <= f[6][`DBG_PC_W-1:0];
    reg_dest_r_type_id_out <= f[7][`DBG_REG_W-1:0];
    reg_dest_l_type_id_out <= f[8][`DBG_REG_W-1:0];
    reg_dst_id_out         <= f[9][0];
    alu_src_id_out         <= f[10][0];
    mem_to_reg_id_out      <= f[11][0];
    reg_write_id_out       <= f[12][0];
    mem_read_id_out        <= f[13][0];
    mem_write_id_out       <= f[14][0];
    branch_id_out          <= f[15][0];
    alu_op_id_out          <= f[16][1:0];          // Raw ALUOp
    result_ie_out          <= f[17];
    registro_2_ie_out      <= f[18];
    jump_dest_addr_ie_out  <= f[19][`DBG_PC_W-1:0];
    zero_signal_ie_out     <= f[20][0];
    reg_dest_ie_out        <= f[21][`DBG_REG_W-1:0];
    mem_to_reg_ie_out      <= f[22][0];
    reg_write_ie_out       <= f[23][0];
    mem_read_ie_out        <= f[24][0];
    mem_write_ie_out       <= f[25][0];
    branch_ie_out          <= f[26][0];
    mem_data_mem_out       <= f[27];
    alu_result_mem_out     <= f[28];
    reg_dest_mem_out       <= f[29][`DBG_REG_W-1:0];
    mem_to_reg_mem_out     <= f[30][0];
    reg_write_mem_out      <= f[31][0];
  endtask

  task automatic wait_for_empty(input logic level, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (empty !== level && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (empty !== level)
      abort_run($sformatf("empty did not reach %0b within %0d cycles", level, limit));
  endtask

  // rd with nothing held, buffer must stay idle
  task automatic stray_read();
    @(posedge clk);
    rd <= 1'b1;
    @(posedge clk);
    rd <= 1'b0;
    @(negedge clk);
    compare("empty", 32'(empty), 32'h1);
  endtask

  task automatic capture_record(input int base);
    @(posedge clk);
    drive_fields(base, 32'h0);
    wr <= 1'b1;
    @(posedge clk);
    wr <= 1'b0;                                    // Accepted on this edge
    wait_for_empty(1'b0, 4);
  endtask

  // wr while loaded, with every stage value changed
  task automatic ignored_capture(input int base);
    @(posedge clk);
    drive_fields(base, 32'hffff_ffff);
    wr <= 1'b1;
    @(posedge clk);
    wr <= 1'b0;
  endtask

  task automatic read_frame(input int base);
    int          gap;
    logic [31:0] exp_byte;
    for (int k = 0; k < `DBG_FRAME_BYTES; k++)
    begin
      exp_byte = rec_mem[base + FIELD_COUNT + k];
      if (k == PROBE_IDX)
      begin
        ignored_capture(base);
      end
      gap = $unsigned($random(seed)) % (MAX_GAP + 1);
      repeat (gap)
      begin
        @(negedge clk);
        compare("r_data", 32'(r_data), exp_byte);  // Held while rd low
      end
      @(negedge clk);
      compare("r_data", 32'(r_data), exp_byte);
      compare("empty", 32'(empty), 32'h0);
      @(posedge clk);
      rd <= 1'b1;
      @(posedge clk);
      rd <= 1'b0;                                  // Byte consumed here
    end
    @(negedge clk);
    compare("empty", 32'(empty), 32'h1);           // Whole frame taken
  endtask

  initial
  begin
    seed = 60791;
    $readmemh("dv/dump_input.txt", rec_mem);
    if ($isunknown(rec_mem[REC_COUNT*REC_LEN-1]))
      abort_run("data file dv/dump_input.txt is missing or short");
    reset <= 1'b1;
    wr    <= 1'b0;
    rd    <= 1'b0;
    drive_fields(0, 32'h0);
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare("empty", 32'(empty), 32'h1);           // Idle straight out of reset
    for (int r = 0; r < REC_COUNT; r++)
    begin
      stray_read();
      capture_record(r * REC_LEN);
      read_frame(r * REC_LEN);
    end
    $display("STATUS: PASS");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before all frames were read");
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/dbg_pkg.sv
src/snapshot_if.sv
src/stage_capture.sv
src/frame_byte_select.sv
src/readout_ctrl.sv
src/pipeline_debug_buffer.sv
dv/tb_pipeline_debug_buffer.sv

/* Bender.yml */
package:
  name: pipeline_debug_buffer

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/dbg_pkg.sv
      - src/snapshot_if.sv
      - src/stage_capture.sv
      - src/frame_byte_select.sv
      - src/readout_ctrl.sv
      - src/pipeline_debug_buffer.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_pipeline_debug_buffer.sv

/* dv/dump_input.txt */
// Per record one line each of IF ID EX and MEM stage values in port order
// followed by the 56 expected frame bytes starting at byte 0
// Record 1 load word
0C 08 8C220004
00000010 0000002A 00000004 10 00 02 0 1 1 1 1 0 0 0
00001234 DEADBEEF 1C 0 1F 1 1 1 0 0
CAFEF00D 00000014 03 0 1
0C 08 8C 22 00 04 00 00 00 10 00 00 00 2A
00 00 00 04 10 00 02 00 01 01 01 01 00 00
00 00 00 12 34 DE AD BE EF 1C 00 1F 01 01
01 00 00 CA FE F0 0D 00 00 00 14 03 00 01
// Record 2 R-type add
20 1C 00852020
7FFFFFFF 80000001 00002020 48 04 05 1 0 0 1 0 0 0 2
00000000 80000001 A4 1 04 0 1 0 0 0
00000000 FFFFFFFF 1F 0 1
20 1C 00 85 20 20 7F FF FF FF 80 00 00 01
00 00 20 20 48 04 05 01 00 00 01 00 00 00
02 00 00 00 00 80 00 00 01 A4 01 04 00 01
00 00 00 00 00 00 00 FF FF FF FF 1F 00 01
// Record 3 store word with negative offset
FF FB AC43FFFC
00001000 12345678 FFFFFFFC F0 1F 03 0 1 0 0 0 1 0 0
00000FFC 12345678 EF 0 11 0 0 0 1 0
A5A5A5A5 00000FFC 11 1 0
FF FB AC 43 FF FC 00 00 10 00 12 34 56 78
FF FF FF FC F0 1F 03 00 01 00 00 00 01 00
00 00 00 0F FC 12 34 56 78 EF 00 11 00 00
00 01 00 A5 A5 A5 A5 00 00 0F FC 11 01 00
// Record 4 branch with all control bits set and reserved ALUOp
44 40 1085FFF0
0000FFFF 0000FFFF FFFFFFF0 00 1E 05 1 1 1 1 1 1 1 3
FFFFFFFF 0000FFFF 7F 1 1E 1 1 1 1 1
01234567 89ABCDEF 1D 1 1
44 40 10 85 FF F0 00 00 FF FF 00 00 FF FF
FF FF FF F0 00 1E 05 01 01 01 01 01 01 01
03 FF FF FF FF 00 00 FF FF 7F 01 1E 01 01
01 01 01 01 23 45 67 89 AB CD EF 1D 01 01
